// ==== fetch_pkg.sv ====
// fetch front end shared definitions
// widths, RV32I opcodes, class and state enums, inter-block structs
`default_nettype none

package fetch_pkg;

	localparam int ADDR_W = 32;
	localparam int INST_W = 32;
	localparam int QUEUE_DEPTH = 4;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [INST_W-1:0] inst_t;
	typedef logic [1:0]        resp_t;
	typedef logic [QPTR_W-1:0] qptr_t;
	// one extra bit so a full queue is distinct from an empty one
	typedef logic [QPTR_W:0]   qcnt_t;
	typedef logic [6:0]        opcode_t;
	typedef logic [2:0]        funct3_t;
	typedef logic [6:0]        funct7_t;

	localparam addr_t RESET_PC = 32'h8000_0000;
	localparam resp_t RESP_OKAY = 2'b00;

	// RV32I major opcodes
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	// full encodings of the privileged words that are accepted
	localparam inst_t INST_ECALL  = 32'h0000_0073;
	localparam inst_t INST_EBREAK = 32'h0010_0073;
	localparam inst_t INST_MRET   = 32'h3020_0073;

	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_LOAD,
		CLS_STORE,
		CLS_BRANCH,
		CLS_JUMP,
		CLS_UPPER,
		CLS_SYSTEM,
		CLS_ILLEGAL
	} inst_class_e;

	typedef enum logic [1:0] {
		ST_ADDR,
		ST_DATA,
		ST_PUSH
	} fetch_state_e;

	typedef struct packed {
		logic  valid;
		addr_t target;
	} redirect_t;

	typedef struct packed {
		addr_t pc;
		inst_t inst;
		logic  fault;
	} fetch_entry_t;

	typedef struct packed {
		addr_t       pc;
		inst_t       inst;
		inst_class_e cls;
		logic        illegal;
	} dec_out_t;

endpackage

`default_nettype wire

// ==== fetch_unit.sv ====
// fetch unit: PC register and read channel master
// issues one word read at a time and pushes the result into the fetch queue
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    flush_i,
	input  fetch_pkg::addr_t        target_i,
	output fetch_pkg::addr_t        ar_addr_o,
	output logic                    ar_valid_o,
	input  logic                    ar_ready_i,
	input  fetch_pkg::inst_t        r_data_i,
	input  fetch_pkg::resp_t        r_resp_i,
	input  logic                    r_valid_i,
	output logic                    r_ready_o,
	output fetch_pkg::fetch_entry_t push_o,
	output logic                    push_valid_o,
	input  logic                    full_i
);

	fetch_pkg::fetch_state_e state_q;
	fetch_pkg::fetch_state_e state_d;
	fetch_pkg::addr_t        pc_q;
	fetch_pkg::addr_t        pc_d;
	fetch_pkg::addr_t        req_addr_q;
	fetch_pkg::addr_t        flush_pc;
	fetch_pkg::inst_t        inst_q;
	logic                    fault_q;
	logic                    discard_q;
	logic                    ar_hs;
	logic                    r_hs;

	// word aligned fetch target
	assign flush_pc = {target_i[fetch_pkg::ADDR_W-1:2], 2'b00};

	assign ar_valid_o = (state_q == fetch_pkg::ST_ADDR);
	assign ar_addr_o  = req_addr_q;
	// hold off the data phase while the queue has no room
	assign r_ready_o  = (state_q == fetch_pkg::ST_DATA) && !full_i;

	assign ar_hs = ar_valid_o && ar_ready_i;
	assign r_hs  = r_ready_o && r_valid_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			fetch_pkg::ST_ADDR: begin
				if (ar_hs) begin
					state_d = fetch_pkg::ST_DATA;
				end
			end
			fetch_pkg::ST_DATA: begin
				if (r_hs) begin
					state_d = fetch_pkg::ST_PUSH;
				end
			end
			default: begin
				state_d = fetch_pkg::ST_ADDR;
			end
		endcase
	end

	// next stream address; a discarded response leaves the new stream where it is
	always_comb begin
		if (flush_i) begin
			pc_d = flush_pc;
		end else if (state_q == fetch_pkg::ST_PUSH && !discard_q) begin
			pc_d = pc_q + fetch_pkg::addr_t'(4);
		end else begin
			pc_d = pc_q;
		end
	end

	// reset parks in ST_PUSH with discard set, so the first launch
	// goes through the normal PUSH to ADDR path
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q    <= fetch_pkg::ST_PUSH;
			pc_q       <= fetch_pkg::RESET_PC;
			req_addr_q <= fetch_pkg::RESET_PC;
			discard_q  <= 1'b1;
		end else begin
			state_q <= state_d;
			pc_q    <= pc_d;
			// request address only changes when a new request is launched
			if (state_q == fetch_pkg::ST_PUSH) begin
				req_addr_q <= pc_d;
			end
			// a read already in flight belongs to the old stream
			if (flush_i) begin
				discard_q <= (state_q != fetch_pkg::ST_PUSH);
			end else if (state_q == fetch_pkg::ST_PUSH) begin
				discard_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (r_hs) begin
			inst_q  <= r_data_i;
			fault_q <= (r_resp_i != fetch_pkg::RESP_OKAY);
		end
	end

	assign push_valid_o = (state_q == fetch_pkg::ST_PUSH) && !discard_q && !flush_i;
	assign push_o.pc    = req_addr_q;
	assign push_o.inst  = inst_q;
	assign push_o.fault = fault_q;

endmodule

`default_nettype wire

// ==== fetch_queue.sv ====
// fetch queue: circular FIFO of fetch entries
// cleared as a whole on redirect
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    flush_i,
	input  fetch_pkg::fetch_entry_t push_i,
	input  logic                    push_valid_i,
	output logic                    full_o,
	output fetch_pkg::fetch_entry_t pop_o,
	output logic                    pop_valid_o,
	input  logic                    pop_ready_i
);

	fetch_pkg::fetch_entry_t mem [fetch_pkg::QUEUE_DEPTH];
	fetch_pkg::qptr_t        wr_ptr_q;
	fetch_pkg::qptr_t        rd_ptr_q;
	fetch_pkg::qcnt_t        count_q;
	logic                    push_en;
	logic                    pop_en;

	assign full_o      = (count_q == fetch_pkg::qcnt_t'(fetch_pkg::QUEUE_DEPTH));
	assign pop_valid_o = (count_q != '0);
	assign pop_o       = mem[rd_ptr_q];

	// nothing moves in a flush cycle
	assign push_en = push_valid_i && !full_o && !flush_i;
	assign pop_en  = pop_valid_o && pop_ready_i && !flush_i;

	always_ff @(posedge clk) begin
		if (push_en) begin
			mem[wr_ptr_q] <= push_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			// depth is a power of two, pointers wrap on their own
			if (push_en) begin
				wr_ptr_q <= wr_ptr_q + fetch_pkg::qptr_t'(1);
			end
			if (pop_en) begin
				rd_ptr_q <= rd_ptr_q + fetch_pkg::qptr_t'(1);
			end
			case ({push_en, pop_en})
				2'b10:   count_q <= count_q + fetch_pkg::qcnt_t'(1);
				2'b01:   count_q <= count_q - fetch_pkg::qcnt_t'(1);
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== inst_check.sv ====
// instruction checker: RV32I subset legality and class
// one-entry output register towards decode
`timescale 1ns/1ps
`default_nettype none

module inst_check (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    flush_i,
	input  fetch_pkg::fetch_entry_t entry_i,
	input  logic                    entry_valid_i,
	output logic                    entry_ready_o,
	output fetch_pkg::dec_out_t     dec_o,
	output logic                    dec_valid_o,
	input  logic                    dec_ready_i
);

	fetch_pkg::opcode_t     opcode;
	fetch_pkg::funct3_t     funct3;
	fetch_pkg::funct7_t     funct7;
	fetch_pkg::inst_class_e cls;
	fetch_pkg::dec_out_t    dec_q;
	logic                   valid_q;

	assign opcode = entry_i.inst[6:0];
	assign funct3 = entry_i.inst[14:12];
	assign funct7 = entry_i.inst[31:25];

	always_comb begin
		cls = fetch_pkg::CLS_ILLEGAL;
		case (opcode)
			fetch_pkg::OPC_LUI, fetch_pkg::OPC_AUIPC: cls = fetch_pkg::CLS_UPPER;
			fetch_pkg::OPC_JAL: cls = fetch_pkg::CLS_JUMP;
			fetch_pkg::OPC_JALR: begin
				if (funct3 == 3'b000) begin
					cls = fetch_pkg::CLS_JUMP;
				end
			end
			fetch_pkg::OPC_BRANCH: cls = fetch_pkg::CLS_BRANCH;
			fetch_pkg::OPC_LOAD: begin
				// lb lh lw lbu lhu
				if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
					cls = fetch_pkg::CLS_LOAD;
				end
			end
			fetch_pkg::OPC_STORE: begin
				if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010) begin
					cls = fetch_pkg::CLS_STORE;
				end
			end
			fetch_pkg::OPC_OP_IMM: begin
				case (funct3)
					3'b001: if (funct7 == 7'b0000000) cls = fetch_pkg::CLS_ALU;
					// srli or srai
					3'b101: if (funct7 == 7'b0000000 || funct7 == 7'b0100000)
						cls = fetch_pkg::CLS_ALU;
					default: cls = fetch_pkg::CLS_ALU;
				endcase
			end
			fetch_pkg::OPC_OP: cls = fetch_pkg::CLS_ALU;
			fetch_pkg::OPC_SYSTEM: begin
				// csrrw csrrs, plus the three exact system words
				if (funct3 == 3'b001 || funct3 == 3'b010 ||
					entry_i.inst == fetch_pkg::INST_ECALL ||
					entry_i.inst == fetch_pkg::INST_EBREAK ||
					entry_i.inst == fetch_pkg::INST_MRET) begin
					cls = fetch_pkg::CLS_SYSTEM;
				end
			end
			default: cls = fetch_pkg::CLS_ILLEGAL;
		endcase
		// a bus error overrides whatever the word looks like
		if (entry_i.fault) begin
			cls = fetch_pkg::CLS_ILLEGAL;
		end
	end

	// take a new entry when empty or when the held one leaves this cycle
	assign entry_ready_o = !valid_q || dec_ready_i;

	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			valid_q <= 1'b0;
		end else if (entry_ready_o) begin
			valid_q <= entry_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (entry_ready_o && entry_valid_i) begin
			dec_q.pc      <= entry_i.pc;
			dec_q.inst    <= entry_i.inst;
			dec_q.cls     <= cls;
			dec_q.illegal <= (cls == fetch_pkg::CLS_ILLEGAL);
		end
	end

	assign dec_o       = dec_q;
	assign dec_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== fetch_top.sv ====
// instruction fetch front end
// fetch unit, fetch queue and checker on one redirect flush
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
	input  logic                 clk,
	input  logic                 rst,
	input  fetch_pkg::redirect_t redirect_i,
	output fetch_pkg::addr_t     ar_addr_o,
	output logic                 ar_valid_o,
	input  logic                 ar_ready_i,
	input  fetch_pkg::inst_t     r_data_i,
	input  fetch_pkg::resp_t     r_resp_i,
	input  logic                 r_valid_i,
	output logic                 r_ready_o,
	output fetch_pkg::dec_out_t  dec_o,
	output logic                 dec_valid_o,
	input  logic                 dec_ready_i
);

	fetch_pkg::fetch_entry_t push_entry;
	logic                    push_valid;
	logic                    full;
	fetch_pkg::fetch_entry_t pop_entry;
	logic                    pop_valid;
	logic                    pop_ready;

	fetch_unit i_fetch_unit (
		.clk          (clk),
		.rst          (rst),
		.flush_i      (redirect_i.valid),
		.target_i     (redirect_i.target),
		.ar_addr_o    (ar_addr_o),
		.ar_valid_o   (ar_valid_o),
		.ar_ready_i   (ar_ready_i),
		.r_data_i     (r_data_i),
		.r_resp_i     (r_resp_i),
		.r_valid_i    (r_valid_i),
		.r_ready_o    (r_ready_o),
		.push_o       (push_entry),
		.push_valid_o (push_valid),
		.full_i       (full)
	);

	fetch_queue i_fetch_queue (
		.clk          (clk),
		.rst          (rst),
		.flush_i      (redirect_i.valid),
		.push_i       (push_entry),
		.push_valid_i (push_valid),
		.full_o       (full),
		.pop_o        (pop_entry),
		.pop_valid_o  (pop_valid),
		.pop_ready_i  (pop_ready)
	);

	inst_check i_inst_check (
		.clk           (clk),
		.rst           (rst),
		.flush_i       (redirect_i.valid),
		.entry_i       (pop_entry),
		.entry_valid_i (pop_valid),
		.entry_ready_o (pop_ready),
		.dec_o         (dec_o),
		.dec_valid_o   (dec_valid_o),
		.dec_ready_i   (dec_ready_i)
	);

endmodule

`default_nettype wire

// ==== fetch_asserts.sv ====
// protocol checks for the fetch front end
// read channel stability and decode handshake hold, bound into fetch_top
`timescale 1ns/1ps
`default_nettype none

module fetch_asserts (
	input logic                 clk,
	input logic                 rst,
	input fetch_pkg::redirect_t redirect_i,
	input fetch_pkg::addr_t     ar_addr_i,
	input logic                 ar_valid_i,
	input logic                 ar_ready_i,
	input logic                 r_ready_i,
	input logic                 queue_full_i,
	input fetch_pkg::dec_out_t  dec_i,
	input logic                 dec_valid_i,
	input logic                 dec_ready_i
);

	// address phase holds until accepted
	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
		else $error("read address changed or dropped before acceptance");

	a_ar_align: assert property (@(posedge clk) disable iff (rst)
		ar_valid_i |-> ar_addr_i[1:0] == 2'b00)
		else $error("read address not word aligned");

	// a stalled output keeps its word unless the stream is redirected
	a_dec_hold: assert property (@(posedge clk) disable iff (rst)
		dec_valid_i && !dec_ready_i && !redirect_i.valid |=> dec_valid_i && $stable(dec_i))
		else $error("decode output changed while stalled");

	a_full_stall: assert property (@(posedge clk) disable iff (rst)
		queue_full_i |-> !r_ready_i)
		else $error("data phase accepted while fetch queue full");

endmodule

`default_nettype wire

// ==== tb_fetch_top.sv ====
// testbench for the fetch front end
// memory responder, table of fetch scenarios, checks on every decode transfer
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

	typedef struct packed {
		int               redir_cyc;
		fetch_pkg::addr_t target;
		int               stall;
		int               n_words;
	} test_row_t;

	logic                 clk;
	logic                 rst;
	fetch_pkg::redirect_t redirect_i;
	fetch_pkg::addr_t     ar_addr_o;
	logic                 ar_valid_o;
	logic                 ar_ready_i;
	fetch_pkg::inst_t     r_data_i;
	fetch_pkg::resp_t     r_resp_i;
	logic                 r_valid_i;
	logic                 r_ready_o;
	fetch_pkg::dec_out_t  dec_o;
	logic                 dec_valid_o;
	logic                 dec_ready_i;

	test_row_t        rows [6];
	string            row_name [6];
	int               errors = 0;
	int               checks = 0;
	int               max_cycles = 3000;
	// memory responder state, one read in flight at most
	logic             pend;
	fetch_pkg::addr_t pend_addr;
	int               delay;

	fetch_top i_fetch_top (
		.clk         (clk),
		.rst         (rst),
		.redirect_i  (redirect_i),
		.ar_addr_o   (ar_addr_o),
		.ar_valid_o  (ar_valid_o),
		.ar_ready_i  (ar_ready_i),
		.r_data_i    (r_data_i),
		.r_resp_i    (r_resp_i),
		.r_valid_i   (r_valid_i),
		.r_ready_o   (r_ready_o),
		.dec_o       (dec_o),
		.dec_valid_o (dec_valid_o),
		.dec_ready_i (dec_ready_i)
	);

	bind fetch_top fetch_asserts i_fetch_asserts (
		.clk          (clk),
		.rst          (rst),
		.redirect_i   (redirect_i),
		.ar_addr_i    (ar_addr_o),
		.ar_valid_i   (ar_valid_o),
		.ar_ready_i   (ar_ready_i),
		.r_ready_i    (r_ready_o),
		.queue_full_i (full),
		.dec_i        (dec_o),
		.dec_valid_i  (dec_valid_o),
		.dec_ready_i  (dec_ready_i)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// program image at the reset address, one word of each class, then rejected words
	function automatic fetch_pkg::inst_t image_word(input fetch_pkg::addr_t a);
		fetch_pkg::addr_t off;
		fetch_pkg::inst_t w;
		logic [21:0]      fold;
		off = a - fetch_pkg::RESET_PC;
		case (off[5:2])
			4'd0:    w = 32'h1234_50b7; // lui
			4'd1:    w = 32'h0000_0097; // auipc
			4'd2:    w = 32'h0000_006f; // jal
			4'd3:    w = 32'h0000_8067; // jalr
			4'd4:    w = 32'h0000_0063; // beq
			4'd5:    w = 32'h0000_a103; // lw
			4'd6:    w = 32'h0020_a023; // sw
			4'd7:    w = 32'h0010_0093; // addi
			4'd8:    w = 32'h4030_d093; // srai
			4'd9:    w = 32'h0020_81b3; // add, on the faulting address
			4'd10:   w = 32'h3000_9073; // csrrw
			4'd11:   w = 32'h0000_0073; // ecall
			4'd12:   w = 32'h0210_9093; // slli with funct7 set
			4'd13:   w = 32'h3000_b073; // csrrc
			4'd14:   w = 32'h0000_b103; // load funct3 011
			default: w = 32'h0000_007f; // unknown opcode
		endcase
		// outside the image an addi whose fields are folded from the word address
		if (off >= 32'h40) begin
			fold = a[23:2] ^ {14'd0, a[31:24]};
			w    = {fold[21:10], fold[9:5], 3'b000, fold[4:0], 7'b0010011};
		end
		return w;
	endfunction

	function automatic logic is_fault(input fetch_pkg::addr_t a);
		return a == fetch_pkg::RESET_PC + 32'h24;
	endfunction

	// RV32I subset rule, fault forces illegal
	function automatic fetch_pkg::inst_class_e exp_class(input fetch_pkg::inst_t w,
		input logic flt);
		logic [6:0]             op;
		logic [2:0]             f3;
		logic [6:0]             f7;
		fetch_pkg::inst_class_e c;
		op = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		c  = fetch_pkg::CLS_ILLEGAL;
		if (op == 7'h37 || op == 7'h17)
			c = fetch_pkg::CLS_UPPER;
		else if (op == 7'h6f || (op == 7'h67 && f3 == 3'd0))
			c = fetch_pkg::CLS_JUMP;
		else if (op == 7'h63)
			c = fetch_pkg::CLS_BRANCH;
		else if (op == 7'h03 && f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5})
			c = fetch_pkg::CLS_LOAD;
		else if (op == 7'h23 && f3 inside {3'd0, 3'd1, 3'd2})
			c = fetch_pkg::CLS_STORE;
		else if (op == 7'h13 && f3 inside {3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7})
			c = fetch_pkg::CLS_ALU;
		else if (op == 7'h13 && f3 == 3'd1 && f7 == 7'h00)
			c = fetch_pkg::CLS_ALU;
		else if (op == 7'h13 && f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20))
			c = fetch_pkg::CLS_ALU;
		else if (op == 7'h33)
			c = fetch_pkg::CLS_ALU;
		else if (op == 7'h73 && (f3 == 3'd1 || f3 == 3'd2))
			c = fetch_pkg::CLS_SYSTEM;
		else if (w == 32'h0000_0073 || w == 32'h0010_0073 || w == 32'h3020_0073)
			c = fetch_pkg::CLS_SYSTEM;
		if (flt)
			c = fetch_pkg::CLS_ILLEGAL;
		return c;
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s is %h, expected %h", what, got, exp);
		end
	endtask

	// drives the read channel for this cycle and notes what completes at the next edge
	task automatic drive_memory(input int stall);
		if (pend && delay > 0)
			delay--;
		ar_ready_i = !pend && (($urandom % 100) >= stall);
		r_valid_i  = pend && (delay == 0);
		r_data_i   = image_word(pend_addr);
		r_resp_i   = is_fault(pend_addr) ? 2'b10 : fetch_pkg::RESP_OKAY;
		if (r_valid_i && r_ready_o)
			pend = 1'b0;
		if (ar_valid_o && ar_ready_i) begin
			pend      = 1'b1;
			pend_addr = ar_addr_o;
			delay     = (stall == 0) ? 0 : int'($urandom % 4);
		end
	endtask

	task automatic run_test(input int idx);
		test_row_t              row;
		int                     cyc;
		int                     redir_at;
		int                     count;
		int                     err_start;
		logic                   after;
		fetch_pkg::addr_t       base;
		fetch_pkg::addr_t       pc;
		fetch_pkg::inst_t       w;
		fetch_pkg::inst_class_e c;
		row       = rows[idx];
		err_start = errors;
		redir_at  = (row.redir_cyc == 0) ? 0 : row.redir_cyc + int'($urandom % 8);
		@(negedge clk);
		rst         = 1'b1;
		redirect_i  = '0;
		ar_ready_i  = 1'b0;
		r_valid_i   = 1'b0;
		dec_ready_i = 1'b0;
		pend        = 1'b0;
		repeat (2) @(negedge clk);
		compare("ar_valid_o", 32'(ar_valid_o), 32'h0);
		compare("r_ready_o", 32'(r_ready_o), 32'h0);
		compare("dec_valid_o", 32'(dec_valid_o), 32'h0);
		rst   = 1'b0;
		base  = fetch_pkg::RESET_PC;
		count = 0;
		after = (redir_at == 0);
		cyc   = 0;
		while (!(after && count >= row.n_words) && cyc < max_cycles) begin
			@(negedge clk);
			cyc++;
			if (cyc == 1) begin
				compare("ar_valid_o", 32'(ar_valid_o), 32'h1);
				compare("ar_addr_o", ar_addr_o, fetch_pkg::RESET_PC);
			end
			// one cycle redirect pulse, new stream starts after it
			if (redirect_i.valid) begin
				redirect_i = '0;
				after      = 1'b1;
				base       = row.target;
				count      = 0;
			end
			if (cyc == redir_at) begin
				redirect_i.valid  = 1'b1;
				redirect_i.target = row.target;
			end
			dec_ready_i = (($urandom % 100) >= row.stall);
			// memory stalls lighter than decode so the fetch queue can fill
			drive_memory(row.stall / 3);
			if (dec_valid_o && dec_ready_i) begin
				pc = base + fetch_pkg::addr_t'(4 * count);
				w  = image_word(pc);
				c  = exp_class(w, is_fault(pc));
				compare("dec_o.pc", dec_o.pc, pc);
				compare("dec_o.inst", dec_o.inst, w);
				compare("dec_o.cls", 32'(dec_o.cls), 32'(c));
				compare("dec_o.illegal", 32'(dec_o.illegal), 32'(c == fetch_pkg::CLS_ILLEGAL));
				count++;
			end
		end
		if (!(after && count >= row.n_words)) begin
			errors++;
			$display("Timeout: test %s delivered %0d of %0d words in %0d cycles",
				row_name[idx], count, row.n_words, cyc);
		end
		$display("test %s: %0d words after last stream start, %0d errors",
			row_name[idx], count, errors - err_start);
	endtask

	initial begin
		rst         = 1'b1;
		redirect_i  = '0;
		ar_ready_i  = 1'b0;
		r_data_i    = '0;
		r_resp_i    = fetch_pkg::RESP_OKAY;
		r_valid_i   = 1'b0;
		dec_ready_i = 1'b0;
		pend        = 1'b0;
		pend_addr   = fetch_pkg::RESET_PC;
		delay       = 0;
		void'($urandom(32'hcaed_8703));
		// redirect cycle (0 is none), target, decode stall percent, words to see
		row_name[0] = "sequential";
		rows[0]     = '{0, fetch_pkg::RESET_PC, 0, 8};
		row_name[1] = "classify";
		rows[1]     = '{0, fetch_pkg::RESET_PC, 0, 18};
		row_name[2] = "backpressure";
		rows[2]     = '{0, fetch_pkg::RESET_PC, 90, 24};
		row_name[3] = "redirect";
		rows[3]     = '{6, fetch_pkg::RESET_PC + 32'h30, 30, 8};
		row_name[4] = "redirect_far";
		rows[4]     = '{10, fetch_pkg::RESET_PC + 32'h100, 50, 6};
		row_name[5] = "read_error";
		rows[5]     = '{3, fetch_pkg::RESET_PC + 32'h20, 20, 4};
		for (int i = 0; i < 6; i++) begin
			run_test(i);
		end
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
fetch_pkg.sv
fetch_unit.sv
fetch_queue.sv
inst_check.sv
fetch_top.sv
fetch_asserts.sv
tb_fetch_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FLAGS     ?= --assert --timing
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' tb.f)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SRCS) tb.f
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f tb.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q -F '** FAIL **' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q -F '** PASS **' $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir $(LOG)
